// File: common/soc_io_params.svh
// widths, depths, register map and shift divider for the io subsystem
`ifndef SOC_IO_PARAMS_SVH
`define SOC_IO_PARAMS_SVH

// bus
`define IO_DATA_W       32
`define IO_ADDR_W       4

// keyboard side
`define KB_CODE_W       8
`define KB_FIFO_DEPTH   8

// display side
`define SEG_FIFO_DEPTH  4
// seg_clk half period is 2**SEG_DIV_LOG2 clk200m cycles
`define SEG_DIV_LOG2    2

// register map, word addresses
`define ADDR_KB         0
`define ADDR_SWT        1
`define ADDR_LED        2
`define ADDR_SEG        3
`define ADDR_STAT       4

`endif

// File: common/io_bus_pkg.sv
// register bus request and response types for the processor side
`include "soc_io_params.svh"

package io_bus_pkg;

    // one request per cycle, at most one strobe high
    typedef struct packed {
        // word address
        logic [`IO_ADDR_W-1:0] addr;
        // write payload, ignored on reads
        logic [`IO_DATA_W-1:0] wdata;
        // write strobe
        logic                  we;
        // read strobe
        logic                  re;
    } io_req_t;

    // response comes back one cycle after re
    typedef struct packed {
        logic                  rvalid;
        logic [`IO_DATA_W-1:0] rdata;
    } io_rsp_t;

endpackage

// File: common/periph_pkg.sv
// payload types for keyboard codes, display words and the status register
`include "soc_io_params.svh"

package periph_pkg;

    // one ps/2 scan code
    typedef logic [`KB_CODE_W-1:0] kb_code_t;

    // one word for the seven-segment chain
    typedef logic [`IO_DATA_W-1:0] seg_word_t;

    // keyboard queue fill level, 0 up to depth
    typedef logic [$clog2(`KB_FIFO_DEPTH+1)-1:0] kb_count_t;

    // status word, sits in the low bits of rdata
    // kb_count lowest, then overflow, display full, shifter busy
    typedef struct packed {
        logic      seg_busy;
        logic      seg_full;
        logic      kb_overflow;
        kb_count_t kb_count;
    } io_status_t;

endpackage

// File: ps2/ps2_rx.sv
// ps/2 receiver, samples the data line on ps2_clk falling edges and checks each frame
`include "soc_io_params.svh"

module ps2_rx (
    input  logic                 clk200m,
    input  logic                 rst,
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    output logic                 code_valid,
    output periph_pkg::kb_code_t code
);
    import periph_pkg::*;

    // about 4k cycles without a falling edge drops a partial frame
    localparam int IDLE_W = 12;

    // two sync flops plus one delay stage for edge detect
    logic [2:0]        clk_sync;
    logic [1:0]        data_sync;
    logic              fall;
    // start, 8 data, parity, stop
    logic [10:0]       frame_sr;
    logic [3:0]        bit_cnt;
    logic [IDLE_W-1:0] idle_cnt;
    logic              frame_done;
    logic              frame_ok;
    kb_code_t          frame_code;

    // sync both lines into clk200m
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            clk_sync  <= 3'b111;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    // high for one cycle when the synced clock goes low
    assign fall = clk_sync[2] & ~clk_sync[1];

    // shift in LSB first, start bit ends up at bit 0
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (bit_cnt == 4'd11) begin
                // stop bit is in, hand frame to the check stage
                bit_cnt    <= '0;
                frame_done <= 1'b1;
            end else if (fall) begin
                bit_cnt <= bit_cnt + 4'd1;
            end else if (&idle_cnt && bit_cnt != 4'd0) begin
                // line went quiet mid frame
                bit_cnt <= '0;
            end

            if (fall) begin
                idle_cnt <= '0;
            end else if (!(&idle_cnt)) begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    // frame payload shift register
    always_ff @(posedge clk200m) begin
        if (fall && bit_cnt != 4'd11) begin
            frame_sr <= {data_sync[1], frame_sr[10:1]};
        end
    end

    // start low, stop high, odd parity over data plus parity bit
    assign frame_code = frame_sr[8:1];
    assign frame_ok   = ~frame_sr[0] & frame_sr[10] & (^frame_sr[9:1]);

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            code_valid <= 1'b0;
        end else begin
            code_valid <= frame_done & frame_ok;
        end
    end

    always_ff @(posedge clk200m) begin
        if (frame_done) begin
            code <= frame_code;
        end
    end

endmodule

// File: design/io_fifo.sv
// small synchronous circular queue, payload type given as a parameter
module io_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic                         clk200m,
    input  logic                         rst,
    input  logic                         push,
    input  payload_t                     push_data,
    input  logic                         pop,
    output payload_t                     pop_data,
    output logic                         full,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH+1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // wrap at DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        ptr_next = (ptr == PTR_W'(DEPTH-1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // push on full and pop on empty fall through
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // oldest entry always on the output
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk200m) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: design/io_regs.sv
// register block, decodes the bus, holds leds and overflow, drives queue strobes
`include "soc_io_params.svh"

module io_regs (
    input  logic                  clk200m,
    input  logic                  rst,
    input  io_bus_pkg::io_req_t   bus_req,
    output io_bus_pkg::io_rsp_t   bus_rsp,
    input  logic [7:0]            swt,
    output logic [7:0]            leds,
    input  logic                  kb_push_drop,
    input  periph_pkg::kb_code_t  kb_data,
    input  logic                  kb_empty,
    input  periph_pkg::kb_count_t kb_count,
    output logic                  kb_pop,
    input  logic                  seg_full,
    output logic                  seg_push,
    output periph_pkg::seg_word_t seg_push_data,
    input  logic                  seg_busy
);
    import io_bus_pkg::*;
    import periph_pkg::*;

    logic [1:0][7:0] swt_sync;
    logic            kb_overflow;
    logic            rd_kb;
    io_status_t      status;
    io_rsp_t         rsp_d;

    // address hits
    assign rd_kb    = bus_req.re && (bus_req.addr == `IO_ADDR_W'(`ADDR_KB));
    assign kb_pop   = rd_kb & ~kb_empty;
    // full queue drops the word here
    assign seg_push = bus_req.we && (bus_req.addr == `IO_ADDR_W'(`ADDR_SEG)) && !seg_full;
    assign seg_push_data = bus_req.wdata;

    assign status = '{
        seg_busy:    seg_busy,
        seg_full:    seg_full,
        kb_overflow: kb_overflow,
        kb_count:    kb_count
    };

    // next read response
    always_comb begin
        rsp_d.rvalid = bus_req.re;
        rsp_d.rdata  = '0;
        if (bus_req.re) begin
            case (bus_req.addr)
                `IO_ADDR_W'(`ADDR_KB): begin
                    // empty queue reads as zero
                    if (!kb_empty) begin
                        rsp_d.rdata[`KB_CODE_W-1:0] = kb_data;
                        rsp_d.rdata[`KB_CODE_W]     = 1'b1;
                    end
                end
                `IO_ADDR_W'(`ADDR_SWT): rsp_d.rdata[7:0] = swt_sync[1];
                `IO_ADDR_W'(`ADDR_STAT): rsp_d.rdata[$bits(io_status_t)-1:0] = status;
                default: rsp_d.rdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            bus_rsp     <= '0;
            leds        <= '0;
            kb_overflow <= 1'b0;
            swt_sync    <= '0;
        end else begin
            bus_rsp  <= rsp_d;
            swt_sync <= {swt_sync[0], swt};
            if (bus_req.we && bus_req.addr == `IO_ADDR_W'(`ADDR_LED)) begin
                leds <= bus_req.wdata[7:0];
            end
            // a new drop wins over the clear
            if (kb_push_drop) begin
                kb_overflow <= 1'b1;
            end else if (rd_kb) begin
                kb_overflow <= 1'b0;
            end
        end
    end

endmodule

// File: seg/seg_serial.sv
// serial shifter, clears the seven-segment chain then sends one word MSB first
`include "soc_io_params.svh"

module seg_serial (
    input  logic                  clk200m,
    input  logic                  rst,
    input  logic                  word_empty,
    input  periph_pkg::seg_word_t word,
    output logic                  take,
    output logic                  busy,
    output logic                  seg_clk,
    output logic                  seg_clrn,
    output logic                  seg_dout,
    output logic                  seg_en
);
    import periph_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_SHIFT
    } phase_t;

    phase_t                 state;
    logic [`SEG_DIV_LOG2:0] div_cnt;
    logic                   fall_tick;
    seg_word_t              shreg;
    logic [4:0]             bit_cnt;

    // free running divider, msb is seg_clk
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign seg_clk = div_cnt[`SEG_DIV_LOG2];
    // seg_clk drops at the end of this cycle
    assign fall_tick = &div_cnt;

    // only start frames on a falling edge so clrn spans a full period
    assign take = (state == ST_IDLE) && !word_empty && fall_tick;
    assign busy = (state != ST_IDLE);

    // everything below moves on falling edges of seg_clk
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            seg_clrn <= 1'b1;
            seg_en   <= 1'b0;
            seg_dout <= 1'b0;
        end else if (fall_tick) begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        seg_clrn <= 1'b0;
                        state    <= ST_CLEAR;
                    end
                end
                ST_CLEAR: begin
                    // clear done, first bit out together with enable
                    seg_clrn <= 1'b1;
                    seg_en   <= 1'b1;
                    seg_dout <= shreg[$bits(seg_word_t)-1];
                    bit_cnt  <= '0;
                    state    <= ST_SHIFT;
                end
                ST_SHIFT: begin
                    if (bit_cnt == 5'd31) begin
                        seg_en   <= 1'b0;
                        seg_dout <= 1'b0;
                        state    <= ST_IDLE;
                    end else begin
                        seg_dout <= shreg[$bits(seg_word_t)-1];
                        bit_cnt  <= bit_cnt + 5'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // shift register, loaded on take, moves one bit per output bit
    always_ff @(posedge clk200m) begin
        if (take) begin
            shreg <= word;
        end else if (fall_tick && state != ST_IDLE) begin
            shreg <= {shreg[$bits(seg_word_t)-2:0], 1'b0};
        end
    end

endmodule

// File: design/io_top.sv
// io subsystem top, ps/2 receiver and display shifter behind the register bus
`include "soc_io_params.svh"

module io_top (
    input  logic                clk200m,
    input  logic                rst,
    input  io_bus_pkg::io_req_t bus_req,
    output io_bus_pkg::io_rsp_t bus_rsp,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    input  logic [7:0]          swt,
    output logic [7:0]          leds,
    output logic                seg_clk,
    output logic                seg_clrn,
    output logic                seg_dout,
    output logic                seg_en
);
    import periph_pkg::*;

    // keyboard path
    logic      code_valid;
    kb_code_t  code;
    kb_code_t  kb_data;
    logic      kb_full;
    logic      kb_empty;
    kb_count_t kb_count;
    logic      kb_pop;
    logic      kb_push_drop;

    // display path
    logic      seg_push;
    seg_word_t seg_push_data;
    seg_word_t seg_word;
    logic      seg_full;
    logic      seg_empty;
    logic      seg_take;
    logic      seg_busy;

    // code arriving on a full queue is lost
    assign kb_push_drop = code_valid & kb_full;

    ps2_rx u_ps2_rx (
        .clk200m    (clk200m),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .code_valid (code_valid),
        .code       (code)
    );

    io_fifo #(.payload_t(kb_code_t), .DEPTH(`KB_FIFO_DEPTH)) u_kb_fifo (
        .clk200m   (clk200m),
        .rst       (rst),
        .push      (code_valid),
        .push_data (code),
        .pop       (kb_pop),
        .pop_data  (kb_data),
        .full      (kb_full),
        .empty     (kb_empty),
        .count     (kb_count)
    );

    io_fifo #(.payload_t(seg_word_t), .DEPTH(`SEG_FIFO_DEPTH)) u_seg_fifo (
        .clk200m   (clk200m),
        .rst       (rst),
        .push      (seg_push),
        .push_data (seg_push_data),
        .pop       (seg_take),
        .pop_data  (seg_word),
        .full      (seg_full),
        .empty     (seg_empty),
        .count     ()
    );

    io_regs u_io_regs (
        .clk200m       (clk200m),
        .rst           (rst),
        .bus_req       (bus_req),
        .bus_rsp       (bus_rsp),
        .swt           (swt),
        .leds          (leds),
        .kb_push_drop  (kb_push_drop),
        .kb_data       (kb_data),
        .kb_empty      (kb_empty),
        .kb_count      (kb_count),
        .kb_pop        (kb_pop),
        .seg_full      (seg_full),
        .seg_push      (seg_push),
        .seg_push_data (seg_push_data),
        .seg_busy      (seg_busy)
    );

    seg_serial u_seg_serial (
        .clk200m    (clk200m),
        .rst        (rst),
        .word_empty (seg_empty),
        .word       (seg_word),
        .take       (seg_take),
        .busy       (seg_busy),
        .seg_clk    (seg_clk),
        .seg_clrn   (seg_clrn),
        .seg_dout   (seg_dout),
        .seg_en     (seg_en)
    );

endmodule

// File: bench/io_tb_clk.sv
// testbench clock source, free running square wave
module io_tb_clk #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    // toggle every half period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// File: bench/io_assert.sv
// concurrent checks on bus response timing, keyboard pops and display framing
`include "soc_io_params.svh"

module io_tb_assert (
    input logic                  clk200m,
    input logic                  rst,
    input io_bus_pkg::io_req_t   bus_req,
    input io_bus_pkg::io_rsp_t   bus_rsp,
    input logic                  kb_empty,
    input periph_pkg::kb_count_t kb_count,
    input logic                  seg_en,
    input logic                  seg_clrn
);

    // bumped on every failed property
    int err_count = 0;

    // response exactly one cycle after the read strobe
    a_rvalid_after_re: assert property (@(posedge clk200m) disable iff (rst)
        bus_req.re |=> bus_rsp.rvalid)
    else begin
        $error("rvalid missing one cycle after read strobe");
        err_count++;
    end

    // and never without one
    a_no_stray_rvalid: assert property (@(posedge clk200m) disable iff (rst)
        !bus_req.re |=> !bus_rsp.rvalid)
    else begin
        $error("rvalid without a preceding read strobe");
        err_count++;
    end

    // a keyboard read on an empty queue must not wrap the fill count
    a_no_pop_empty: assert property (@(posedge clk200m) disable iff (rst)
        (bus_req.re && bus_req.addr == `IO_ADDR_W'(`ADDR_KB) && kb_empty)
            |=> (kb_count <= 1))
    else begin
        $error("keyboard queue popped while empty");
        err_count++;
    end

    // enable may only come up once the clear is over
    a_en_after_clear: assert property (@(posedge clk200m) disable iff (rst)
        $rose(seg_en) |-> seg_clrn)
    else begin
        $error("seg_en rose while seg_clrn low");
        err_count++;
    end

endmodule

bind io_top io_tb_assert u_io_assert (
    .clk200m  (clk200m),
    .rst      (rst),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .kb_empty (kb_empty),
    .kb_count (kb_count),
    .seg_en   (seg_en),
    .seg_clrn (seg_clrn)
);

// File: bench/io_tb.sv
// testbench for the io subsystem, plays the processor and the keyboard and checks a model
`include "soc_io_params.svh"

module io_tb;
    import io_bus_pkg::*;

    localparam logic [`IO_ADDR_W-1:0] A_KB   = `IO_ADDR_W'(`ADDR_KB);
    localparam logic [`IO_ADDR_W-1:0] A_SWT  = `IO_ADDR_W'(`ADDR_SWT);
    localparam logic [`IO_ADDR_W-1:0] A_LED  = `IO_ADDR_W'(`ADDR_LED);
    localparam logic [`IO_ADDR_W-1:0] A_SEG  = `IO_ADDR_W'(`ADDR_SEG);
    localparam logic [`IO_ADDR_W-1:0] A_STAT = `IO_ADDR_W'(`ADDR_STAT);

    logic        clk200m;
    logic        rst;
    io_req_t     bus_req;
    io_rsp_t     bus_rsp;
    logic        ps2_clk;
    logic        ps2_data;
    logic [7:0]  swt;
    logic [7:0]  leds;
    logic        seg_clk;
    logic        seg_clrn;
    logic        seg_dout;
    logic        seg_en;

    // lfsr state, reference queues, display monitor
    logic [15:0] lfsr = 16'd54392;
    logic [7:0]  kb_model[$];
    logic        kb_ovf = 1'b0;
    logic [31:0] exp_words[$];
    logic [31:0] got_words[$];
    logic [31:0] mon_sr = '0;
    int          mon_bits = 0;
    logic        clr_seen = 1'b0;

    io_tb_clk #(.PERIOD(8)) u_clk (.clk(clk200m));

    io_top dut (
        .clk200m  (clk200m),
        .rst      (rst),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .swt      (swt),
        .leds     (leds),
        .seg_clk  (seg_clk),
        .seg_clrn (seg_clrn),
        .seg_dout (seg_dout),
        .seg_en   (seg_en)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic stop_failed();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            $display("[ERROR] %s actual 0x%08h expected 0x%08h", name, act, exp);
            stop_failed();
        end
    endtask

    // count lowest, then overflow, display full, shifter busy
    function automatic logic [31:0] status_word(input int cnt, input logic ovf,
                                                input logic full, input logic busy);
        return {25'b0, busy, full, ovf, 4'(cnt)};
    endfunction

    task automatic bus_write(input logic [`IO_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk200m);
        bus_req <= '{addr: addr, wdata: data, we: 1'b1, re: 1'b0};
        @(posedge clk200m);
        bus_req <= '0;
    endtask

    task automatic bus_read(input logic [`IO_ADDR_W-1:0] addr, output logic [31:0] data);
        logic got;
        got = 1'b0;
        @(posedge clk200m);
        bus_req <= '{addr: addr, wdata: '0, we: 1'b0, re: 1'b1};
        @(posedge clk200m);
        bus_req <= '0;
        for (int n = 0; n < 4 && !got; n++) begin
            @(negedge clk200m);
            got = bus_rsp.rvalid;
        end
        if (!got) begin
            $display("timeout: no rvalid came back after a read strobe");
            stop_failed();
        end
        data = bus_rsp.rdata;
    endtask

    task automatic read_check(input logic [`IO_ADDR_W-1:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] rd;
        bus_read(addr, rd);
        check_value(name, rd, exp);
    endtask

    // model side of a received code, drop when full
    task automatic model_push(input logic [7:0] c);
        if (kb_model.size() < `KB_FIFO_DEPTH) begin
            kb_model.push_back(c);
        end else begin
            kb_ovf = 1'b1;
        end
    endtask

    task automatic kb_read_expect();
        logic [31:0] exp;
        exp = '0;
        if (kb_model.size() > 0) begin
            exp = {23'b0, 1'b1, kb_model.pop_front()};
        end
        // every keyboard read clears overflow
        kb_ovf = 1'b0;
        read_check(A_KB, exp, "kb_data");
    endtask

    // start, 8 data LSB first, odd parity, stop; bad flips parity
    task automatic send_frame(input logic [7:0] c, input logic bad);
        logic [10:0] frame;
        logic        seen;
        seen  = 1'b0;
        frame = {1'b1, (~^c) ^ bad, c, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk200m);
            ps2_data <= frame[i];
            repeat (40) @(posedge clk200m);
            ps2_clk <= 1'b0;
            // code_valid lands inside the low half of the stop bit
            for (int n = 0; n < 40; n++) begin
                @(negedge clk200m);
                if (i == 10 && dut.code_valid) begin
                    seen = 1'b1;
                end
            end
            @(posedge clk200m);
            ps2_clk <= 1'b1;
        end
        if (!bad && !seen) begin
            $display("timeout: code_valid never pulsed after a good PS/2 frame");
            stop_failed();
        end
        if (bad && seen) begin
            $display("code_valid pulsed for a frame with wrong parity");
            stop_failed();
        end
    endtask

    task automatic wait_seg_clk_fall();
        logic prev;
        logic fell;
        fell = 1'b0;
        @(negedge clk200m);
        prev = seg_clk;
        for (int n = 0; n < 32 && !fell; n++) begin
            @(negedge clk200m);
            fell = prev && !seg_clk;
            prev = seg_clk;
        end
        if (!fell) begin
            $display("timeout: seg_clk never fell");
            stop_failed();
        end
    endtask

    // rebuild display words, dout is steady at seg_clk rise
    always @(posedge seg_clk) begin
        if (!seg_clrn) begin
            clr_seen = 1'b1;
        end
        if (seg_en) begin
            if (mon_bits == 0 && !clr_seen) begin
                $display("display frame started without a low seg_clrn before it");
                stop_failed();
            end
            mon_sr = {mon_sr[30:0], seg_dout};
            mon_bits++;
            if (mon_bits == 32) begin
                got_words.push_back(mon_sr);
                mon_bits = 0;
                clr_seen = 1'b0;
            end
        end
    end

    // stop at the first bound assertion failure
    always @(negedge clk200m) begin
        if (dut.u_io_assert.err_count != 0) begin
            $display("a bound assertion failed during the run");
            stop_failed();
        end
    end

    initial begin
        logic [31:0] v;
        logic [31:0] rd;
        int          n;
        rst      = 1'b1;
        bus_req  = '0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        swt      = '0;
        repeat (16) @(posedge clk200m);
        rst <= 1'b0;

        // one frame, one read
        for (int i = 0; i < 16; i++) begin
            rand_bits(8, v);
            send_frame(v[7:0], 1'b0);
            model_push(v[7:0]);
            kb_read_expect();
        end
        kb_read_expect();

        // wrong parity never reaches the queue
        rand_bits(8, v);
        send_frame(v[7:0], 1'b1);
        kb_read_expect();
        rand_bits(8, v);
        send_frame(v[7:0], 1'b0);
        model_push(v[7:0]);
        kb_read_expect();

        // nine codes into a queue of eight
        for (int i = 0; i < 9; i++) begin
            rand_bits(8, v);
            send_frame(v[7:0], 1'b0);
            model_push(v[7:0]);
        end
        read_check(A_STAT, status_word(kb_model.size(), kb_ovf, 1'b0, 1'b0), "status");
        kb_read_expect();
        read_check(A_STAT, status_word(kb_model.size(), kb_ovf, 1'b0, 1'b0), "status");
        for (int i = 0; i < 7; i++) begin
            kb_read_expect();
        end
        kb_read_expect();

        // switches through the two sync flops
        for (int i = 0; i < 6; i++) begin
            rand_bits(8, v);
            @(posedge clk200m);
            swt <= v[7:0];
            repeat (4) @(posedge clk200m);
            read_check(A_SWT, {24'b0, v[7:0]}, "swt");
        end

        // leds follow one cycle after the write
        for (int i = 0; i < 6; i++) begin
            rand_bits(8, v);
            bus_write(A_LED, v);
            @(negedge clk200m);
            check_value("leds", {24'b0, leds}, {24'b0, v[7:0]});
        end
        read_check(A_LED, 32'h0, "led register read");

        // five writes right after a seg_clk fall, last one hits a full queue
        wait_seg_clk_fall();
        for (int i = 0; i < 5; i++) begin
            rand_bits(32, v);
            @(posedge clk200m);
            bus_req <= '{addr: A_SEG, wdata: v, we: 1'b1, re: 1'b0};
            if (i < 4) begin
                exp_words.push_back(v);
            end
        end
        @(posedge clk200m);
        bus_req <= '0;

        // first frame on the wire, three words still queued
        for (n = 0; n < 100 && !seg_en; n++) begin
            @(negedge clk200m);
        end
        if (!seg_en) begin
            $display("timeout: seg_en never went high for the first display frame");
            stop_failed();
        end
        read_check(A_STAT, status_word(0, 1'b0, 1'b0, 1'b1), "status while shifting");

        for (n = 0; n < 4000 && got_words.size() < 4; n++) begin
            @(negedge clk200m);
        end
        if (got_words.size() < 4) begin
            $display("timeout: not all display frames were shifted out");
            stop_failed();
        end
        for (int i = 0; i < 4; i++) begin
            check_value("seg word", got_words[i], exp_words[i]);
        end

        // shifter back to idle, everything drained
        rd = status_word(0, 1'b0, 1'b0, 1'b1);
        for (n = 0; n < 20 && rd[6]; n++) begin
            bus_read(A_STAT, rd);
        end
        check_value("status", rd, status_word(0, 1'b0, 1'b0, 1'b0));
        check_value("seg frame count", got_words.size(), 32'd4);

        if (dut.u_io_assert.err_count != 0) begin
            $display("a bound assertion failed during the run");
            stop_failed();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: filelist.f
+incdir+common
common/io_bus_pkg.sv
common/periph_pkg.sv
ps2/ps2_rx.sv
design/io_fifo.sv
design/io_regs.sv
seg/seg_serial.sv
design/io_top.sv
bench/io_tb_clk.sv
bench/io_assert.sv
bench/io_tb.sv
